//--- src/calc_consts.svh
// Calculator constants: datapath widths, completion pipe depth and stage positions

`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// Operand and result word
`define CALC_DWORD_WIDTH 32

// Integer register index, x0..x31
`define CALC_REG_ADDR_WIDTH 5

// Instruction address
`define CALC_PC_WIDTH 32

// Index of the last completion stage, stages 0..4 exist
`define CALC_COMP_DEPTH 4

// Completion stage that the multiplier result joins
`define CALC_MUL_LATENCY 3

// Completion stage that raises the commit strobe
`define CALC_COMMIT_STAGE 2

`endif

//--- src/calc_isa_pkg.sv
// Architectural types of the calculator: data word, register index, pc and ALU operation
`default_nettype none

`include "calc_consts.svh"

package calc_isa_pkg;

  typedef logic [`CALC_DWORD_WIDTH-1:0] dword_t;

  typedef logic [`CALC_REG_ADDR_WIDTH-1:0] reg_addr_t;

  typedef logic [`CALC_PC_WIDTH-1:0] pc_t;

  // Encodings are fixed, the pattern file uses them directly
  typedef enum logic [2:0]
  {
    e_alu_add = 3'd0
    , e_alu_sub = 3'd1
    , e_alu_and = 3'd2
    , e_alu_or  = 3'd3
    , e_alu_xor = 3'd4
    , e_alu_slt = 3'd5
  } alu_op_e;

endpackage

`default_nettype wire

//--- src/calc_pipe_pkg.sv
// Pipeline types of the calculator: execute pipe select and completion stage index
`default_nettype none

`include "calc_consts.svh"

package calc_pipe_pkg;

  // Which execute pipe produces the result of an instruction
  typedef enum logic [0:0]
  {
    e_pipe_int = 1'b0
    , e_pipe_mul = 1'b1
  } pipe_sel_e;

  // Wide enough to name every completion stage 0..CALC_COMP_DEPTH
  typedef logic [$clog2(`CALC_COMP_DEPTH+1)-1:0] stage_idx_t;

endpackage

`default_nettype wire

//--- src/calc_bypass.sv
// Operand bypass: picks the youngest in-flight result for each source register
`default_nettype none
`timescale 1ns/10ps

`include "calc_consts.svh"

module calc_bypass
  import calc_isa_pkg::*;
 (input reg_addr_t                          rs1_addr_i
  , input reg_addr_t                        rs2_addr_i
  , input dword_t                           rs1_data_i
  , input dword_t                           rs2_data_i

  // Taps from completion stages 1..4, stage 1 is the youngest
  , input logic [`CALC_COMP_DEPTH:1]        fwd_v_i
  , input reg_addr_t [`CALC_COMP_DEPTH:1]   fwd_addr_i
  , input dword_t [`CALC_COMP_DEPTH:1]      fwd_data_i

  , output dword_t                          rs1_o
  , output dword_t                          rs2_o
  );

  function automatic dword_t select_fwd
    (input reg_addr_t                         addr
     , input dword_t                          rf_data
     , input logic [`CALC_COMP_DEPTH:1]       v
     , input reg_addr_t [`CALC_COMP_DEPTH:1]  tap_addr
     , input dword_t [`CALC_COMP_DEPTH:1]     tap_data
     );
    dword_t sel;
    // x0 reads as zero and never takes a tap
    sel = (addr == '0) ? '0 : rf_data;
    // Walk oldest to youngest so the youngest match is the one left standing
    for (int i = `CALC_COMP_DEPTH; i >= 1; i--)
    begin
      if (v[i] && (tap_addr[i] == addr) && (addr != '0))
        sel = tap_data[i];
    end
    return sel;
  endfunction

  assign rs1_o = select_fwd(rs1_addr_i, rs1_data_i, fwd_v_i, fwd_addr_i, fwd_data_i);
  assign rs2_o = select_fwd(rs2_addr_i, rs2_data_i, fwd_v_i, fwd_addr_i, fwd_data_i);

endmodule

`default_nettype wire

//--- src/calc_issue.sv
// Issue register: stage 0 of the pipe, holds the dispatched instruction with bypassed operands
`default_nettype none
`timescale 1ns/10ps

`include "calc_consts.svh"

module calc_issue
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
 (input logic                               clk_i
  , input logic                             reset_i

  // Dispatch
  , input logic                             dispatch_v_i
  , input logic                             poison_i
  , input pc_t                              pc_i
  , input pipe_sel_e                        pipe_sel_i
  , input alu_op_e                          alu_op_i
  , input logic                             use_imm_i
  , input dword_t                           imm_i
  , input reg_addr_t                        rs1_addr_i
  , input reg_addr_t                        rs2_addr_i
  , input dword_t                           rs1_data_i
  , input dword_t                           rs2_data_i
  , input reg_addr_t                        rd_addr_i
  , input logic                             rd_w_v_i

  , input logic                             flush_i

  // Forwarding taps from completion
  , input logic [`CALC_COMP_DEPTH:1]        fwd_v_i
  , input reg_addr_t [`CALC_COMP_DEPTH:1]   fwd_addr_i
  , input dword_t [`CALC_COMP_DEPTH:1]      fwd_data_i

  // Stage 0 contents
  , output logic                            v_o
  , output logic                            poison_o
  , output pc_t                             pc_o
  , output pipe_sel_e                       pipe_sel_o
  , output alu_op_e                         alu_op_o
  , output dword_t                          op_a_o
  , output dword_t                          op_b_o
  , output reg_addr_t                       rd_addr_o
  , output logic                            rd_w_v_o
  );

  dword_t rs1_byp;
  dword_t rs2_byp;

  calc_bypass bypass
   (.rs1_addr_i(rs1_addr_i)
    ,.rs2_addr_i(rs2_addr_i)
    ,.rs1_data_i(rs1_data_i)
    ,.rs2_data_i(rs2_data_i)
    ,.fwd_v_i(fwd_v_i)
    ,.fwd_addr_i(fwd_addr_i)
    ,.fwd_data_i(fwd_data_i)
    ,.rs1_o(rs1_byp)
    ,.rs2_o(rs2_byp)
    );

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_o      <= 1'b0;
      poison_o <= 1'b0;
    end
    else
    begin
      v_o      <= dispatch_v_i;
      // A flush kills the instruction arriving in the same cycle
      poison_o <= poison_i | flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    pc_o       <= pc_i;
    pipe_sel_o <= pipe_sel_i;
    alu_op_o   <= alu_op_i;
    op_a_o     <= rs1_byp;
    op_b_o     <= use_imm_i ? imm_i : rs2_byp;
    rd_addr_o  <= rd_addr_i;
    rd_w_v_o   <= rd_w_v_i;
  end

  // Nothing sits in stage 0 right after reset
  reset_empty_a: assert property (@(posedge clk_i) reset_i |=> !v_o);

endmodule

`default_nettype wire

//--- src/calc_pipe_int.sv
// Integer execute pipe: single-cycle ALU fed from stage 0
`default_nettype none
`timescale 1ns/10ps

module calc_pipe_int
  import calc_isa_pkg::*;
 (input alu_op_e                            alu_op_i
  , input dword_t                           op_a_i
  , input dword_t                           op_b_i

  , output dword_t                          data_o
  );

  logic slt_lo;

  // Signed compare for slt
  assign slt_lo = ($signed(op_a_i) < $signed(op_b_i));

  always_comb
  begin
    case (alu_op_i)
      e_alu_add:
        data_o = op_a_i + op_b_i;
      e_alu_sub:
        data_o = op_a_i - op_b_i;
      e_alu_and:
        data_o = op_a_i & op_b_i;
      e_alu_or:
        data_o = op_a_i | op_b_i;
      e_alu_xor:
        data_o = op_a_i ^ op_b_i;
      e_alu_slt:
        data_o = {{($bits(dword_t)-1){1'b0}}, slt_lo};
      // Unused encodings give zero
      default:
        data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/calc_pipe_mul.sv
// Multiplier execute pipe: operands and low product word each take one register stage
`default_nettype none
`timescale 1ns/10ps

module calc_pipe_mul
  import calc_isa_pkg::*;
 (input logic                               clk_i
  , input logic                             reset_i

  , input dword_t                           op_a_i
  , input dword_t                           op_b_i

  // Valid in the cycle the instruction sits in completion stage 2
  , output dword_t                          data_o
  );

  dword_t op_a_r;
  dword_t op_b_r;
  dword_t prod_r;

  // First register, captured as the instruction leaves stage 0
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      op_a_r <= '0;
      op_b_r <= '0;
    end
    else
    begin
      op_a_r <= op_a_i;
      op_b_r <= op_b_i;
    end
  end

  // Second register keeps only the low word of the product
  always_ff @(posedge clk_i)
  begin
    prod_r <= op_a_r * op_b_r;
  end

  assign data_o = prod_r;

endmodule

`default_nettype wire

//--- src/calc_completion.sv
// Completion pipe: stage, poison and result shift registers with forwarding, commit and writeback
`default_nettype none
`timescale 1ns/10ps

`include "calc_consts.svh"

module calc_completion
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
 (input logic                               clk_i
  , input logic                             reset_i
  , input logic                             flush_i

  // Stage 0 from the issue register
  , input logic                             v_i
  , input logic                             poison_i
  , input pc_t                              pc_i
  , input pipe_sel_e                        pipe_sel_i
  , input reg_addr_t                        rd_addr_i
  , input logic                             rd_w_v_i

  // Execute pipe results
  , input dword_t                           int_data_i
  , input dword_t                           mul_data_i

  // Forwarding taps, next state of stages 1..4
  , output logic [`CALC_COMP_DEPTH:1]       fwd_v_o
  , output reg_addr_t [`CALC_COMP_DEPTH:1]  fwd_addr_o
  , output dword_t [`CALC_COMP_DEPTH:1]     fwd_data_o

  , output logic                            commit_v_o
  , output pc_t                             commit_pc_o

  , output logic                            wb_v_o
  , output reg_addr_t                       wb_addr_o
  , output dword_t                          wb_data_o
  );

  localparam stage_idx_t commit_stage_lp = stage_idx_t'(`CALC_COMMIT_STAGE);
  localparam stage_idx_t mul_stage_lp    = stage_idx_t'(`CALC_MUL_LATENCY);
  localparam stage_idx_t last_stage_lp   = stage_idx_t'(`CALC_COMP_DEPTH);

  logic [`CALC_COMP_DEPTH:1] v_n, v_r;
  logic [`CALC_COMP_DEPTH:1] poison_n, poison_r;
  logic [`CALC_COMP_DEPTH:1] rd_w_v_n, rd_w_v_r;
  pc_t       pc_n       [1:`CALC_COMP_DEPTH];
  pc_t       pc_r       [1:`CALC_COMP_DEPTH];
  pipe_sel_e pipe_sel_n [1:`CALC_COMP_DEPTH];
  pipe_sel_e pipe_sel_r [1:`CALC_COMP_DEPTH];
  reg_addr_t rd_addr_n  [1:`CALC_COMP_DEPTH];
  reg_addr_t rd_addr_r  [1:`CALC_COMP_DEPTH];
  dword_t    result_n   [1:`CALC_COMP_DEPTH];
  dword_t    result_r   [1:`CALC_COMP_DEPTH];

  always_comb
  begin
    // Stage 1 takes the issue register, and the ALU result for int ops
    v_n[1]         = v_i;
    poison_n[1]    = poison_i | flush_i;
    rd_w_v_n[1]    = rd_w_v_i;
    pc_n[1]        = pc_i;
    pipe_sel_n[1]  = pipe_sel_i;
    rd_addr_n[1]   = rd_addr_i;
    result_n[1]    = (pipe_sel_i == e_pipe_int) ? int_data_i : '0;

    for (int i = 2; i <= `CALC_COMP_DEPTH; i++)
    begin
      v_n[i]        = v_r[i-1];
      // Flush reaches up to the commit stage, never past it
      poison_n[i]   = poison_r[i-1] | (flush_i && (i <= commit_stage_lp));
      rd_w_v_n[i]   = rd_w_v_r[i-1];
      pc_n[i]       = pc_r[i-1];
      pipe_sel_n[i] = pipe_sel_r[i-1];
      rd_addr_n[i]  = rd_addr_r[i-1];
      result_n[i]   = result_r[i-1];
    end

    // Multiplier result lands as the mul moves out of the stage before
    if (pipe_sel_r[mul_stage_lp-1] == e_pipe_mul)
      result_n[mul_stage_lp] = mul_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_r      <= '0;
      poison_r <= '0;
    end
    else
    begin
      v_r      <= v_n;
      poison_r <= poison_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_w_v_r   <= rd_w_v_n;
    pc_r       <= pc_n;
    pipe_sel_r <= pipe_sel_n;
    rd_addr_r  <= rd_addr_n;
    result_r   <= result_n;
  end

  // Poisoned entries never forward
  always_comb
  begin
    for (int i = 1; i <= `CALC_COMP_DEPTH; i++)
    begin
      fwd_v_o[i]    = v_n[i] & rd_w_v_n[i] & ~poison_n[i];
      fwd_addr_o[i] = rd_addr_n[i];
      fwd_data_o[i] = result_n[i];
    end
  end

  assign commit_v_o  = v_r[commit_stage_lp] & ~poison_r[commit_stage_lp];
  assign commit_pc_o = pc_r[commit_stage_lp];

  assign wb_v_o    = v_r[last_stage_lp] & rd_w_v_r[last_stage_lp] & ~poison_r[last_stage_lp];
  assign wb_addr_o = rd_addr_r[last_stage_lp];
  assign wb_data_o = result_r[last_stage_lp];

  // A committed write always reaches the register file
  commit_wb_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (commit_v_o && rd_w_v_r[commit_stage_lp]) |-> ##2 wb_v_o);

endmodule

`default_nettype wire

//--- src/calc_top.sv
// Calculator top: issue register, integer and multiplier pipes and completion pipe
`default_nettype none
`timescale 1ns/10ps

`include "calc_consts.svh"

module calc_top
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
 (input logic                               clk_i
  , input logic                             reset_i

  , input logic                             dispatch_v_i
  , input logic                             poison_i
  , input pc_t                              pc_i
  , input pipe_sel_e                        pipe_sel_i
  , input alu_op_e                          alu_op_i
  , input logic                             use_imm_i
  , input dword_t                           imm_i
  , input reg_addr_t                        rs1_addr_i
  , input reg_addr_t                        rs2_addr_i
  , input dword_t                           rs1_data_i
  , input dword_t                           rs2_data_i
  , input reg_addr_t                        rd_addr_i
  , input logic                             rd_w_v_i

  , input logic                             flush_i

  , output logic                            commit_v_o
  , output pc_t                             commit_pc_o

  , output logic                            wb_v_o
  , output reg_addr_t                       wb_addr_o
  , output dword_t                          wb_data_o
  );

  // Stage 0
  logic      iss_v;
  logic      iss_poison;
  pc_t       iss_pc;
  pipe_sel_e iss_pipe_sel;
  alu_op_e   iss_alu_op;
  dword_t    iss_op_a;
  dword_t    iss_op_b;
  reg_addr_t iss_rd_addr;
  logic      iss_rd_w_v;

  dword_t int_data;
  dword_t mul_data;

  logic [`CALC_COMP_DEPTH:1]      fwd_v;
  reg_addr_t [`CALC_COMP_DEPTH:1] fwd_addr;
  dword_t [`CALC_COMP_DEPTH:1]    fwd_data;

  calc_issue issue
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.dispatch_v_i(dispatch_v_i)
    ,.poison_i(poison_i)
    ,.pc_i(pc_i)
    ,.pipe_sel_i(pipe_sel_i)
    ,.alu_op_i(alu_op_i)
    ,.use_imm_i(use_imm_i)
    ,.imm_i(imm_i)
    ,.rs1_addr_i(rs1_addr_i)
    ,.rs2_addr_i(rs2_addr_i)
    ,.rs1_data_i(rs1_data_i)
    ,.rs2_data_i(rs2_data_i)
    ,.rd_addr_i(rd_addr_i)
    ,.rd_w_v_i(rd_w_v_i)
    ,.flush_i(flush_i)
    ,.fwd_v_i(fwd_v)
    ,.fwd_addr_i(fwd_addr)
    ,.fwd_data_i(fwd_data)
    ,.v_o(iss_v)
    ,.poison_o(iss_poison)
    ,.pc_o(iss_pc)
    ,.pipe_sel_o(iss_pipe_sel)
    ,.alu_op_o(iss_alu_op)
    ,.op_a_o(iss_op_a)
    ,.op_b_o(iss_op_b)
    ,.rd_addr_o(iss_rd_addr)
    ,.rd_w_v_o(iss_rd_w_v)
    );

  calc_pipe_int pipe_int
   (.alu_op_i(iss_alu_op)
    ,.op_a_i(iss_op_a)
    ,.op_b_i(iss_op_b)
    ,.data_o(int_data)
    );

  calc_pipe_mul pipe_mul
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.op_a_i(iss_op_a)
    ,.op_b_i(iss_op_b)
    ,.data_o(mul_data)
    );

  calc_completion completion
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.flush_i(flush_i)
    ,.v_i(iss_v)
    ,.poison_i(iss_poison)
    ,.pc_i(iss_pc)
    ,.pipe_sel_i(iss_pipe_sel)
    ,.rd_addr_i(iss_rd_addr)
    ,.rd_w_v_i(iss_rd_w_v)
    ,.int_data_i(int_data)
    ,.mul_data_i(mul_data)
    ,.fwd_v_o(fwd_v)
    ,.fwd_addr_o(fwd_addr)
    ,.fwd_data_o(fwd_data)
    ,.commit_v_o(commit_v_o)
    ,.commit_pc_o(commit_pc_o)
    ,.wb_v_o(wb_v_o)
    ,.wb_addr_o(wb_addr_o)
    ,.wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

//--- testbench/calc_tb_checks.svh
// Testbench compare tasks: typed checks of DUT results and failure reporting

`ifndef CALC_TB_CHECKS_SVH
`define CALC_TB_CHECKS_SVH

// Print the reason, then the fail message, then stop
task automatic report_failure(input string what);
  $display("%s", what);
  $display("Something failed");
  $fatal(1, "Stopped at first error");
endtask

task automatic check_data(input string name, input dword_t exp, input dword_t act);
  if (act !== exp)
  begin
    report_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  end
endtask

task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
  if (act !== exp)
  begin
    report_failure($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
  end
endtask

task automatic check_pc(input string name, input pc_t exp, input pc_t act);
  if (act !== exp)
  begin
    report_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  end
endtask

`endif

//--- testbench/calc_tb.sv
// Calculator testbench: replays the pattern file and scores commit and writeback
`default_nettype none
`timescale 1ns/10ps

`include "calc_consts.svh"

module calc_tb
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
  ();

  localparam int cols_lp      = 12;
  localparam int max_rows_lp  = 64;
  localparam int max_slots_lp = 512;

  logic clk = 1'b0;
  logic reset;
  int   cycle = 0;

  logic      dispatch_v, poison, use_imm, rd_w_v, flush;
  pc_t       pc;
  pipe_sel_e pipe_sel;
  alu_op_e   alu_op;
  dword_t    imm, rs1_data, rs2_data;
  reg_addr_t rs1_addr, rs2_addr, rd_addr;

  logic      commit_v, wb_v;
  pc_t       commit_pc;
  reg_addr_t wb_addr;
  dword_t    wb_data;

  logic [31:0] pat_mem [0:max_rows_lp*cols_lp-1];

  // Reference register file as seen at writeback, so in-flight results are stale here
  dword_t rf [0:31];
  integer seed;
  int     applied_upto = -1;
  int     last_slot = 0;
  int     commit_cnt = 0;
  int     wb_cnt = 0;

  // Per sample edge: what the DUT took in at that edge
  bit        slot_v    [0:max_slots_lp-1];
  bit        slot_dead [0:max_slots_lp-1];
  bit        slot_wv   [0:max_slots_lp-1];
  pc_t       slot_pc   [0:max_slots_lp-1];
  reg_addr_t slot_rd   [0:max_slots_lp-1];
  dword_t    slot_exp  [0:max_slots_lp-1];

  `include "calc_tb_checks.svh"

  calc_top UUT
   (.clk_i(clk), .reset_i(reset)
    ,.dispatch_v_i(dispatch_v), .poison_i(poison), .pc_i(pc)
    ,.pipe_sel_i(pipe_sel), .alu_op_i(alu_op), .use_imm_i(use_imm), .imm_i(imm)
    ,.rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr)
    ,.rs1_data_i(rs1_data), .rs2_data_i(rs2_data)
    ,.rd_addr_i(rd_addr), .rd_w_v_i(rd_w_v), .flush_i(flush)
    ,.commit_v_o(commit_v), .commit_pc_o(commit_pc)
    ,.wb_v_o(wb_v), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

  always #4 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  // Read a source register the way an external register file would
  function automatic dword_t read_rf(input reg_addr_t addr);
    dword_t junk;
    junk = $random(seed);
    // x0 data is junk on purpose, the bypass must force zero
    return (addr == '0) ? junk : rf[addr];
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    dispatch_v <= 1'b0;
    poison     <= 1'b0;
    flush      <= 1'b0;
  endtask

  task automatic dispatch_row(input int row);
    int base;
    int s;
    base = row * cols_lp;
    @(posedge clk);
    // Old counter value is seen here, the DUT samples this drive one edge later
    s = cycle + 2;
    if (s >= max_slots_lp)
      report_failure("Run is longer than the slot table");
    // Results written back before edge s are visible in the register file
    for (int e = applied_upto + 1; e <= s - 5; e++)
    begin
      if (slot_v[e] && !slot_dead[e] && slot_wv[e] && slot_rd[e] != '0)
        rf[slot_rd[e]] = slot_exp[e];
      applied_upto = e;
    end
    // Flush also kills what was sampled at the two edges before
    if (pat_mem[base+10][0])
    begin
      for (int e = s - 2; e < s; e++)
        slot_dead[e] = 1'b1;
    end
    slot_v[s]    = 1'b1;
    slot_dead[s] = pat_mem[base+9][0] | pat_mem[base+10][0];
    slot_wv[s]   = pat_mem[base+8][0];
    slot_pc[s]   = pat_mem[base];
    slot_rd[s]   = reg_addr_t'(pat_mem[base+7]);
    slot_exp[s]  = pat_mem[base+11];
    last_slot    = s;

    dispatch_v <= 1'b1;
    pc         <= pat_mem[base];
    pipe_sel   <= pipe_sel_e'(pat_mem[base+1][0]);
    alu_op     <= alu_op_e'(pat_mem[base+2][2:0]);
    use_imm    <= pat_mem[base+3][0];
    imm        <= pat_mem[base+4];
    rs1_addr   <= reg_addr_t'(pat_mem[base+5]);
    rs2_addr   <= reg_addr_t'(pat_mem[base+6]);
    rs1_data   <= read_rf(reg_addr_t'(pat_mem[base+5]));
    rs2_data   <= read_rf(reg_addr_t'(pat_mem[base+6]));
    rd_addr    <= reg_addr_t'(pat_mem[base+7]);
    rd_w_v     <= pat_mem[base+8][0];
    poison     <= pat_mem[base+9][0];
    flush      <= pat_mem[base+10][0];
  endtask

  // Commit belongs to the slot two edges back, writeback to the slot four edges back
  task automatic check_outputs();
    int  ce;
    int  we;
    bit  exp_c;
    bit  exp_w;
    ce = cycle - 2;
    we = cycle - 4;
    exp_c = (ce >= 0) && slot_v[ce] && !slot_dead[ce];
    exp_w = (we >= 0) && slot_v[we] && !slot_dead[we] && slot_wv[we];
    if (exp_c && commit_v !== 1'b1)
      report_failure($sformatf("No commit for pc %h two cycles after dispatch", slot_pc[ce]));
    if (!exp_c && commit_v !== 1'b0)
      report_failure($sformatf("Commit strobe at cycle %0d with nothing to commit", cycle));
    if (exp_c)
    begin
      check_pc($sformatf("commit pc of slot %0d", ce), slot_pc[ce], commit_pc);
    end
    // Count the strobes the DUT actually raised
    if (commit_v === 1'b1)
      commit_cnt++;
    if (exp_w && wb_v !== 1'b1)
      report_failure($sformatf("No writeback for pc %h four cycles after dispatch", slot_pc[we]));
    if (!exp_w && wb_v !== 1'b0)
      report_failure($sformatf("Writeback strobe at cycle %0d with nothing to write", cycle));
    if (exp_w)
    begin
      check_addr($sformatf("wb address of pc %h", slot_pc[we]), slot_rd[we], wb_addr);
      check_data($sformatf("wb data of pc %h", slot_pc[we]), slot_exp[we], wb_data);
    end
    if (wb_v === 1'b1)
      wb_cnt++;
  endtask

  // Outputs are stable in the middle of the cycle
  always @(negedge clk)
  begin
    if (reset === 1'b0)
      check_outputs();
  end

  initial
  begin
    int row;
    int gaps;
    int waited;
    int exp_commits;
    int exp_wbs;
    reset = 1'b1;
    dispatch_v = 1'b0;
    poison = 1'b0;
    pc = '0;
    pipe_sel = e_pipe_int;
    alu_op = e_alu_add;
    use_imm = 1'b0;
    imm = '0;
    rs1_addr = '0;
    rs2_addr = '0;
    rs1_data = '0;
    rs2_data = '0;
    rd_addr = '0;
    rd_w_v = 1'b0;
    flush = 1'b0;
    seed = 32'ha2ce;
    for (int i = 0; i < 32; i++)
      rf[i] = '0;
    $readmemh("testbench/calc_patterns.txt", pat_mem);

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    row = 0;
    while (row < max_rows_lp && pat_mem[row*cols_lp] !== 32'hffffffff)
    begin
      dispatch_row(row);
      // Gaps only widen distances, so the multiply spacing in the file still holds
      gaps = $unsigned($random(seed)) % 3;
      repeat (gaps) idle_cycle();
      row++;
    end
    if (row == max_rows_lp)
      report_failure("Pattern file has no end marker");
    idle_cycle();

    waited = 0;
    while (cycle < last_slot + 6)
    begin
      @(posedge clk);
      waited++;
      if (waited > 40)
        report_failure("Timed out waiting for the pipe to drain");
    end
    @(negedge clk);

    exp_commits = 0;
    exp_wbs = 0;
    for (int e = 0; e <= last_slot; e++)
    begin
      if (slot_v[e] && !slot_dead[e])
      begin
        exp_commits++;
        if (slot_wv[e])
          exp_wbs++;
      end
    end
    if (commit_cnt == exp_commits && wb_cnt == exp_wbs && exp_commits > 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      report_failure($sformatf("Saw %0d commits and %0d writebacks, expected %0d and %0d",
                               commit_cnt, wb_cnt, exp_commits, exp_wbs));
    end
  end

endmodule

`default_nettype wire

//--- testbench/calc_patterns.txt
// pc pipe op use_imm imm rs1 rs2 rd rd_w_v poison flush expected
// pipe 0 int 1 mul, op 0 add 1 sub 2 and 3 or 4 xor 5 slt, last row is the end marker
00000100 0 0 1 00000010 00 00 01 1 0 0 00000010
00000104 0 0 1 00000005 01 00 02 1 0 0 00000015
00000108 0 1 0 00000000 02 01 03 1 0 0 00000005
0000010c 1 0 0 00000000 02 03 04 1 0 0 00000069
00000110 0 4 1 000000f0 02 00 05 1 0 0 000000e5
00000114 0 2 1 0000000f 05 00 06 1 0 0 00000005
00000118 0 3 0 00000000 06 01 07 1 0 0 00000015
0000011c 0 0 0 00000000 04 07 08 1 0 0 0000007e
00000120 0 5 0 00000000 03 02 09 1 0 0 00000001
00000124 0 1 0 00000000 00 08 0a 1 0 0 ffffff82
00000128 0 5 0 00000000 0a 01 0b 1 0 0 00000001
0000012c 0 5 0 00000000 01 0a 0c 1 0 0 00000000
00000130 0 0 1 00000bad 00 00 03 1 1 0 00000bad
00000134 0 0 1 00000001 03 00 0d 1 0 0 00000006
00000138 1 0 0 00000000 0a 0a 0e 1 0 0 00003e04
0000013c 0 0 0 00000000 00 00 0f 1 0 0 00000000
00000140 0 4 0 00000000 0d 09 10 1 0 0 00000007
00000144 0 0 0 00000000 0e 10 11 1 0 0 00003e0b
00000148 0 0 1 00000000 11 00 12 0 0 0 00003e0b
0000014c 0 0 1 00000001 01 00 14 1 0 0 00000011
00000150 0 0 1 00000001 02 00 15 1 0 0 00000016
00000154 0 0 1 00000001 03 00 16 1 0 1 00000006
00000158 0 0 0 00000000 11 08 17 1 0 0 00003e89
0000015c 1 0 1 00000003 17 00 18 1 0 0 0000bb9b
00000160 0 3 0 00000000 0f 0b 19 1 0 0 00000001
ffffffff 0 0 0 00000000 00 00 00 0 0 0 00000000

//--- verilog.f
+incdir+src
+incdir+testbench
src/calc_isa_pkg.sv
src/calc_pipe_pkg.sv
src/calc_bypass.sv
src/calc_issue.sv
src/calc_pipe_int.sv
src/calc_pipe_mul.sv
src/calc_completion.sv
src/calc_top.sv
testbench/calc_tb.sv

//--- Makefile
# Verilator build and run of the calculator testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module calc_tb -f verilog.f

run: build
	./obj_dir/Vcalc_tb | tee /dev/stderr | grep -q "Everything OK"

lint:
	verilator --lint-only -Wall --timing --top-module calc_top -f verilog.f

clean:
	rm -rf obj_dir
